//--- src/relayPkg.sv
package relayPkg;

	localparam int DATA_W = 8; // one register, one bus byte.
	localparam int ADDR_W = 16;
	localparam int MEM_AW = 8; // only the low address byte reaches the data memory.
	localparam int NUM_REGS = 8;

	// Register numbering matches the bit order of the one-hot ld and sel vectors.
	typedef enum logic [2:0]
	{
		A  = 3'd0,
		B  = 3'd1,
		C  = 3'd2,
		D  = 3'd3,
		M1 = 3'd4,
		M2 = 3'd5,
		X  = 3'd6,
		Y  = 3'd7
	} regSelT;

	typedef enum logic [2:0]
	{
		OP_MOV   = 3'd0,
		OP_SET   = 3'd1,
		OP_ALU   = 3'd2,
		OP_INCXY = 3'd3,
		OP_XYM   = 3'd4,
		OP_LOAD  = 3'd5,
		OP_STORE = 3'd6,
		OP_OUT   = 3'd7
	} opcodeT;

	typedef enum logic [2:0]
	{
		ADD = 3'd0,
		INC = 3'd1,
		AND = 3'd2,
		OR  = 3'd3,
		XOR = 3'd4,
		NOT = 3'd5,
		ROL = 3'd6,
		CLR = 3'd7
	} aluOpT;

	typedef enum logic [1:0] {REG, ALU, IMM, MEM} dataSrcT; // data bus source.

	typedef enum logic [1:0] {IDLE, EXEC, MEMRD, EMIT} seqStateT;

	// Instruction word, opcode in the top bits and the immediate in the low byte.
	typedef struct packed
	{
		opcodeT opcode;
		regSelT dst;
		regSelT src;
		aluOpT aluOp;
		logic [DATA_W-1:0] imm;
	} instrT;

	typedef struct packed
	{
		logic [NUM_REGS-1:0] ld;  // one-hot register load.
		logic [NUM_REGS-1:0] sel; // one-hot register onto the data bus.
		dataSrcT dataSrc;
		logic selM;  // address bus shows M1:M2.
		logic selXY; // X:Y reloads from the incrementer.
		logic ldXY;
		logic memWe;
	} ctrlT;

endpackage

//--- src/instrSequencer.sv
module instrSequencer
(
	input  logic clk,
	input  logic rst,
	input  relayPkg::instrT instr,
	input  logic instrValid,
	output logic instrReady,
	output relayPkg::ctrlT ctrl,
	output logic [relayPkg::DATA_W-1:0] imm,
	output relayPkg::aluOpT aluOp,
	input  logic [relayPkg::DATA_W-1:0] dataBus,
	output logic [relayPkg::DATA_W-1:0] outData,
	output logic outValid,
	input  logic outReady
);
	import relayPkg::*;

	seqStateT state;
	instrT instrReg; // instruction being executed.
	logic [NUM_REGS-1:0] dstHot;
	logic [NUM_REGS-1:0] srcHot;

	assign instrReady = (state == IDLE); // a new instruction only enters an idle sequencer.
	assign imm = instrReg.imm;
	assign aluOp = instrReg.aluOp;

	assign dstHot = {{(NUM_REGS-1){1'b0}}, 1'b1} << instrReg.dst;
	assign srcHot = {{(NUM_REGS-1){1'b0}}, 1'b1} << instrReg.src;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			outValid <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (instrValid)
						state <= EXEC;
				end
				EXEC:
				begin
					if (instrReg.opcode == OP_LOAD)
						state <= MEMRD; // memory needs one more cycle for its read.
					else if (instrReg.opcode == OP_OUT)
					begin
						state <= EMIT;
						outValid <= 1'b1;
					end
					else
						state <= IDLE;
				end
				MEMRD: state <= IDLE;
				EMIT:
				begin
					// stall here until the consumer takes the byte.
					if (outReady)
					begin
						state <= IDLE;
						outValid <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (instrReady && instrValid)
			instrReg <= instr;
		if (state == EXEC && instrReg.opcode == OP_OUT)
			outData <= dataBus; // the selected register is on the bus during EXEC.
	end

	// Idle and emit cycles leave every control line low.
	always_comb
	begin
		ctrl = '0;
		if (state == EXEC)
		begin
			case (instrReg.opcode)
				OP_MOV:
				begin
					ctrl.sel = srcHot;
					ctrl.ld = dstHot;
				end
				OP_SET:
				begin
					ctrl.dataSrc = IMM;
					ctrl.ld = dstHot;
				end
				OP_ALU:
				begin
					ctrl.dataSrc = ALU;
					ctrl.ld = dstHot;
				end
				OP_INCXY:
				begin
					ctrl.ldXY = 1'b1; // address bus stays on XY and feeds the incrementer.
					ctrl.selXY = 1'b1;
				end
				OP_XYM:
				begin
					ctrl.selM = 1'b1;
					ctrl.ldXY = 1'b1;
				end
				OP_LOAD: ctrl.selM = 1'b1; // read address goes out this cycle.
				OP_STORE:
				begin
					ctrl.selM = 1'b1;
					ctrl.sel = srcHot;
					ctrl.memWe = 1'b1;
				end
				OP_OUT: ctrl.sel = srcHot;
				default: ctrl = '0;
			endcase
		end
		else if (state == MEMRD)
		begin
			ctrl.selM = 1'b1;
			ctrl.dataSrc = MEM;
			ctrl.ld = dstHot;
		end
	end

endmodule

//--- src/registerUnit.sv
module registerUnit
(
	input  logic clk,
	input  logic rst,
	input  relayPkg::ctrlT ctrl,
	input  logic [relayPkg::DATA_W-1:0] imm,
	input  logic [relayPkg::DATA_W-1:0] aluResult,
	input  logic [relayPkg::DATA_W-1:0] memData,
	input  logic [relayPkg::ADDR_W-1:0] addrInc,
	output logic [relayPkg::DATA_W-1:0] regB,
	output logic [relayPkg::DATA_W-1:0] regC,
	output logic [relayPkg::DATA_W-1:0] dataBus,
	output logic [relayPkg::ADDR_W-1:0] addrBus
);
	import relayPkg::*;

	logic [NUM_REGS-1:0][DATA_W-1:0] regs; // indexed by regSelT.
	logic [DATA_W-1:0] regOut;
	logic [ADDR_W-1:0] xyNext;

	assign regB = regs[B];
	assign regC = regs[C];

	// M1 and X are the high bytes of their pairs.
	assign addrBus = ctrl.selM ? {regs[M1], regs[M2]} : {regs[X], regs[Y]};

	// Sel is one-hot, so an OR of the gated registers picks one of them.
	always_comb
	begin
		regOut = '0;
		for (int i = 0; i < NUM_REGS; i++)
		begin
			if (ctrl.sel[i])
				regOut = regOut | regs[i];
		end
	end

	always_comb
	begin
		case (ctrl.dataSrc)
			REG: dataBus = regOut;
			ALU: dataBus = aluResult;
			IMM: dataBus = imm;
			MEM: dataBus = memData;
			default: dataBus = regOut;
		endcase
	end

	// INCXY takes the incremented address, XYM copies M straight across.
	assign xyNext = ctrl.selXY ? addrInc : addrBus;

	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '0;
		else
		begin
			for (int i = 0; i < NUM_REGS; i++)
			begin
				if (ctrl.ld[i])
					regs[i] <= dataBus;
			end
			if (ctrl.ldXY)
			begin
				regs[X] <= xyNext[ADDR_W-1:DATA_W];
				regs[Y] <= xyNext[DATA_W-1:0]; // carry out of Y already folded into X.
			end
		end
	end

endmodule

//--- src/aluUnit.sv
module aluUnit
(
	input  relayPkg::aluOpT aluOp,
	input  logic [relayPkg::DATA_W-1:0] regB,
	input  logic [relayPkg::DATA_W-1:0] regC,
	input  logic [relayPkg::ADDR_W-1:0] addrBus,
	output logic [relayPkg::DATA_W-1:0] aluResult,
	output logic [relayPkg::ADDR_W-1:0] addrInc
);
	import relayPkg::*;

	// Carries out of bit 7 are dropped since there are no flags.
	always_comb
	begin
		case (aluOp)
			ADD: aluResult = regB + regC;
			INC: aluResult = regB + DATA_W'(1);
			AND: aluResult = regB & regC;
			OR:  aluResult = regB | regC;
			XOR: aluResult = regB ^ regC;
			NOT: aluResult = ~regB;
			ROL: aluResult = {regB[DATA_W-2:0], regB[DATA_W-1]}; // msb wraps into bit 0.
			CLR: aluResult = '0;
			default: aluResult = '0;
		endcase
	end

	// The incrementer wraps FFFF to 0000.
	assign addrInc = addrBus + ADDR_W'(1);

endmodule

//--- src/memoryUnit.sv
module memoryUnit
(
	input  logic clk,
	input  logic [relayPkg::MEM_AW-1:0] addr,
	input  logic [relayPkg::DATA_W-1:0] wdata,
	input  logic we,
	output logic [relayPkg::DATA_W-1:0] rdata
);
	import relayPkg::*;

	logic [DATA_W-1:0] mem [2**MEM_AW];

	// Read data shows up one cycle after the address.
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

//--- src/relayCpu.sv
module relayCpu
(
	input  logic clk,
	input  logic rst,
	input  relayPkg::instrT instr,
	input  logic instrValid,
	output logic instrReady,
	output logic [relayPkg::DATA_W-1:0] outData,
	output logic outValid,
	input  logic outReady
);
	import relayPkg::*;

	ctrlT ctrl;
	aluOpT aluOp;
	logic [DATA_W-1:0] imm;
	logic [DATA_W-1:0] regB;
	logic [DATA_W-1:0] regC;
	logic [DATA_W-1:0] dataBus;
	logic [DATA_W-1:0] aluResult;
	logic [DATA_W-1:0] memData;
	logic [ADDR_W-1:0] addrBus;
	logic [ADDR_W-1:0] addrInc;

	instrSequencer u_instrSequencer
	(
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.ctrl(ctrl),
		.imm(imm),
		.aluOp(aluOp),
		.dataBus(dataBus),
		.outData(outData),
		.outValid(outValid),
		.outReady(outReady)
	);

	registerUnit u_registerUnit
	(
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.imm(imm),
		.aluResult(aluResult),
		.memData(memData),
		.addrInc(addrInc),
		.regB(regB),
		.regC(regC),
		.dataBus(dataBus),
		.addrBus(addrBus)
	);

	aluUnit u_aluUnit
	(
		.aluOp(aluOp),
		.regB(regB),
		.regC(regC),
		.addrBus(addrBus),
		.aluResult(aluResult),
		.addrInc(addrInc)
	);

	// Only the low address byte selects a memory location.
	memoryUnit u_memoryUnit
	(
		.clk(clk),
		.addr(addrBus[MEM_AW-1:0]),
		.wdata(dataBus),
		.we(ctrl.memWe),
		.rdata(memData)
	);

endmodule

//--- tests/relayCpu_chk.sv
module relayCpu_chk
(
	input logic clk,
	input logic rst,
	input relayPkg::ctrlT ctrl,
	input relayPkg::seqStateT state,
	input logic instrValid,
	input logic instrReady,
	input logic [relayPkg::DATA_W-1:0] outData,
	input logic outValid,
	input logic outReady
);
	timeunit 1ns;
	timeprecision 1ps;

	import relayPkg::*;

	// the register unit ORs the selected registers, so two at once would corrupt the bus.
	oneHotCtrl: assert property (@(posedge clk) disable iff (rst)
		$onehot0(ctrl.sel) && $onehot0(ctrl.ld))
		else $error("more than one register selected or loaded in one cycle");

	outHold: assert property (@(posedge clk) disable iff (rst)
		outValid && !outReady |=> outValid && $stable(outData))
		else $error("output stream changed before the consumer took it");

	// an accepted word keeps the sequencer busy for at least the next cycle.
	readyDropsOnAccept: assert property (@(posedge clk) disable iff (rst)
		instrValid && instrReady |=> !instrReady)
		else $error("instruction input still ready in the cycle after a transfer");

	readyLowWhileEmitting: assert property (@(posedge clk) disable iff (rst)
		outValid |-> !instrReady)
		else $error("instruction input ready while an output byte waits");

	writeOnlyExec: assert property (@(posedge clk) disable iff (rst)
		ctrl.memWe |-> state == EXEC)
		else $error("memory write outside the execute state");

endmodule

bind instrSequencer relayCpu_chk u_relayCpu_chk
(
	.clk(clk),
	.rst(rst),
	.ctrl(ctrl),
	.state(state),
	.instrValid(instrValid),
	.instrReady(instrReady),
	.outData(outData),
	.outValid(outValid),
	.outReady(outReady)
);

//--- tests/relayCpu_tb.sv
module relayCpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import relayPkg::*;

	logic clk;
	logic rst;
	instrT instr;
	logic instrValid;
	logic instrReady;
	logic [DATA_W-1:0] outData;
	logic outValid;
	logic outReady;

	instrT instrList[$]; // program, in order.
	logic [DATA_W-1:0] expList[$];
	logic [31:0] lcgState;
	int instrIdx; // next instruction to hand over.
	int outIdx;
	int cycleCount;
	int cycleLimit;

	relayCpu u_relayCpu
	(
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.instrReady(instrReady),
		.outData(outData),
		.outValid(outValid),
		.outReady(outReady)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareValue(input string name, input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] expected);
		if (got !== expected)
			stopWithFailure($sformatf("Mismatch %s: got 0x%02h, expected 0x%02h",
				name, got, expected));
	endtask

	// records are a tag character and a hex value, several may share a line.
	task automatic readStim();
		int fd;
		int code;
		logic [7:0] tag;
		logic [19:0] value;
		logic [8*256-1:0] restOfLine;
		fd = $fopen("tests/relayCpu_stim.txt", "r");
		if (fd == 0)
			stopWithFailure("could not open the stimulus file tests/relayCpu_stim.txt");
		code = $fscanf(fd, " %c", tag);
		while (code == 1)
		begin
			if (tag == "#")
				code = $fgets(restOfLine, fd); // skip the comment.
			else if (tag == "I" || tag == "E")
			begin
				code = $fscanf(fd, "%h", value);
				if (code != 1)
					stopWithFailure("a stimulus record has no hex value after its tag");
				if (tag == "I")
					instrList.push_back(value);
				else
					expList.push_back(value[DATA_W-1:0]);
			end
			else
				stopWithFailure("the stimulus file holds an unknown record tag");
			code = $fscanf(fd, " %c", tag);
		end
		$fclose(fd);
	endtask

	// called right after a rising edge, so the handshake signals still show
	// what the DUT saw at that edge.
	task automatic serviceCycle();
		logic [31:0] rnd;
		logic holding;
		cycleCount++;
		if (cycleCount > cycleLimit)
			stopWithFailure("timeout while waiting for the DUT to finish the program");
		if (outValid && outReady)
		begin
			if (outIdx >= expList.size())
				stopWithFailure("the DUT sent an output byte that the program never asked for");
			compareValue("outData", outData, expList[outIdx]);
			outIdx++;
		end
		holding = instrValid && !instrReady; // an offered word stays until taken.
		if (instrValid && instrReady)
			instrIdx++;
		lcgState = lcgNext(lcgState);
		rnd = lcgState;
		if (!holding)
		begin
			if (instrIdx < instrList.size() && rnd[27:26] != 2'b00)
			begin
				instr <= instrList[instrIdx];
				instrValid <= 1'b1;
			end
			else
				instrValid <= 1'b0; // a gap on the input.
		end
		outReady <= rnd[30];
	endtask

	initial
	begin
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		outReady = 1'b0;
		lcgState = 32'had80;
		instrIdx = 0;
		outIdx = 0;
		cycleCount = 0;
		readStim();
		cycleLimit = 10 * instrList.size() + 100;

		repeat (8) @(posedge clk);
		// a freshly reset sequencer is idle and has nothing to send.
		compareValue("instrReady", instrReady, 1'b1);
		compareValue("outValid", outValid, 1'b0);
		rst <= 1'b0;

		while (instrIdx < instrList.size() || outIdx < expList.size())
		begin
			@(posedge clk);
			serviceCycle();
		end

		// a short quiet window catches any byte sent after the last expected one.
		repeat (20)
		begin
			@(posedge clk);
			serviceCycle();
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

//--- relayCpu.f
src/relayPkg.sv
src/instrSequencer.sv
src/registerUnit.sv
src/aluUnit.sv
src/memoryUnit.sv
src/relayCpu.sv
tests/relayCpu_chk.sv
tests/relayCpu_tb.sv

//--- build.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f relayCpu.f --top-module relayCpu_tb -o relayCpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/relayCpu_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

echo "simulation finished cleanly"
exit 0

//--- tests/relayCpu_stim.txt
# Each I record holds a 20-bit instruction word in hex.
# Each E record holds the next expected output byte in hex.
# after reset every register reads zero
I E0000 E 00  I E0800 E 00
I E1000 E 00  I E1800 E 00
I E2000 E 00  I E2800 E 00
I E3000 E 00  I E3800 E 00
# set each register and send it out
I 2005A I E0000 E 5A
I 2403C I E0800 E 3C
I 280A5 I E1000 E A5
I 2C00F I E1800 E 0F
I 30012 I E2000 E 12
I 34034 I E2800 E 34
I 380C7 I E3000 E C7
I 3C080 I E3800 E 80
# B moves through D and X into A
I 0C800 I 19800 I 03000 I E0000 E 3C I E1800 E 3C I E3000 E 3C
# C moves through Y into M2
I 1D000 I 17800 I E2800 E A5 I E3800 E A5
# ALU ops on B=3C and C=A5 with results in A or D
I 40000 I E0000 E E1
I 4C100 I E1800 E 3D
I 40200 I E0000 E 24
I 4C300 I E1800 E BD
I 40400 I E0000 E 99
I 4C500 I E1800 E C3
I 40600 I E0000 E 78
I 4C700 I E1800 E 00
# B=F0 drops the ADD carry and wraps the top bit on ROL
I 240F0 I 40000 I E0000 E 95 I 4C600 I E1800 E E1
# stores to 10 20 and 30 with M1 changing under them
I 34010 I 20061 I C0000
I 34020 I 20062 I C0000
I 30077 I 34030 I 20063 I C0000
# loads in another order with other M1 values
I 30000 I 34030 I AC000 I E1800 E 63
I 34010 I A4000 I E0800 E 61
I 300AB I 34020 I A8000 I E1000 E 62
# XY takes M=12FE and counts across a Y carry
I 30012 I 340FE I 80000 I 60000 I E3000 E 12 I E3800 E FF
I 60000 I E3000 E 13 I E3800 E 00
# FFFF wraps to 0000
I 300FF I 340FF I 80000 I 60000 I E3000 E 00 I E3800 E 00
